/* files.f */
dcache_pkg.sv
tag_store.sv
line_store.sv
axi_burst_master.sv
dcache_control.sv
dcache_top.sv
tb_axi_memory.sv
tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - files:
      - dcache_pkg.sv
      - tag_store.sv
      - line_store.sv
      - axi_burst_master.sv
      - dcache_control.sv
      - dcache_top.sv
  - target: test
    files:
      - tb_axi_memory.sv
      - tb_dcache.sv

/* tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;

    localparam int seed_value         = 32'ha6478c4f;
    localparam int random_requests    = 40;
    localparam int num_requests       = 12 + random_requests;
    localparam int cycles_per_request = 200;
    localparam int sets               = dcache_pkg::default_sets;
    localparam int ways               = dcache_pkg::default_ways;

    logic                 clock = 1'b0;
    logic                 reset;
    dcache_pkg::cpu_req_t req;
    logic                 ack;
    dcache_pkg::data_t    rdata;
    dcache_pkg::axi_ar_t  ar;
    logic                 arready;
    dcache_pkg::axi_r_t   r;
    logic                 rready;
    dcache_pkg::axi_aw_t  aw;
    logic                 awready;
    dcache_pkg::axi_w_t   w;
    logic                 wready;
    dcache_pkg::axi_b_t   b;
    logic                 bready;

    integer seed     = seed_value;

    // Memory as the CPU sees it, plus which lines sit in which way
    dcache_pkg::data_t model_mem [dcache_pkg::addr_t];
    logic              model_valid [sets][ways];
    logic              model_dirty [sets][ways];
    dcache_pkg::addr_t model_line  [sets][ways];
    int                model_rr;

    logic              check_req;   // High for the sampling edge while ack is up
    logic              check_read;
    int                exp_ar;
    int                exp_aw;
    dcache_pkg::addr_t exp_ar_addr;
    dcache_pkg::addr_t exp_aw_addr;
    dcache_pkg::line_t exp_line;    // Victim line contents for the write burst
    dcache_pkg::data_t exp_rdata;
    int                ar_base;
    int                aw_base;
    int                w_base;

    logic                  reset_q  = 1'b0;
    int                    ar_count = 0;
    int                    aw_count = 0;
    int                    w_count  = 0;
    dcache_pkg::addr_t     last_ar_addr;
    dcache_pkg::addr_t     last_aw_addr;
    dcache_pkg::word_idx_t w_beat   = '0;

    dcache_pkg::addr_t dir_addr [4] = '{32'h0000_1008, 32'h0000_1050,
                                        32'h0000_2018, 32'h0000_2078};
    dcache_pkg::size_t size_codes [5] = '{dcache_pkg::size_byte, dcache_pkg::size_half,
                                          dcache_pkg::size_word, dcache_pkg::size_dword,
                                          3'd0};
    logic              rnd_write;
    dcache_pkg::addr_t rnd_addr;
    dcache_pkg::size_t rnd_size;
    dcache_pkg::data_t rnd_data;

    dcache_top UUT (
        .clock   (clock),
        .reset   (reset),
        .req     (req),
        .ack     (ack),
        .rdata   (rdata),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready),
        .aw      (aw),
        .awready (awready),
        .w       (w),
        .wready  (wready),
        .b       (b),
        .bready  (bready)
    );

    tb_axi_memory #(.seed_init(seed_value)) memory (
        .clock   (clock),
        .reset   (reset),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready),
        .aw      (aw),
        .awready (awready),
        .w       (w),
        .wready  (wready),
        .b       (b),
        .bready  (bready)
    );

    always #10 clock = ~clock;

    task automatic stop_on_failure();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        stop_on_failure();
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        stop_on_failure();
    endtask

    function automatic dcache_pkg::data_t model_word(input dcache_pkg::addr_t a);
        if (model_mem.exists(a)) begin
            return model_mem[a];
        end
        return {32'h0, ~a};
    endfunction

    // Low bytes kept by a sized access, none for an unknown code
    function automatic dcache_pkg::data_t size_mask(input dcache_pkg::size_t size);
        int bytes;
        case (size)
            dcache_pkg::size_byte:  bytes = 1;
            dcache_pkg::size_half:  bytes = 2;
            dcache_pkg::size_word:  bytes = 4;
            dcache_pkg::size_dword: bytes = 8;
            default:                bytes = 0;
        endcase
        size_mask = '0;
        for (int i = 0; i < bytes; i++) begin
            size_mask[8*i +: 8] = 8'hff;
        end
    endfunction

    // Predicts bursts and data, then runs the four-phase handshake
    task automatic run_request(input logic is_write, input dcache_pkg::addr_t addr,
                               input dcache_pkg::size_t size, input dcache_pkg::data_t wdata);
        int                set;
        int                way;
        dcache_pkg::addr_t line;
        dcache_pkg::data_t mask;
        @(negedge clock);
        set    = (addr >> dcache_pkg::offset_bits) % sets;
        line   = addr & ~32'h3f;
        mask   = size_mask(size);
        way    = -1;
        exp_ar = 0;
        exp_aw = 0;
        for (int i = 0; i < ways; i++) begin
            if (model_valid[set][i] && model_line[set][i] == line) way = i;
        end
        if (way < 0) begin
            for (int i = ways - 1; i >= 0; i--) begin
                if (!model_valid[set][i]) way = i;  // Lowest empty way
            end
            if (way < 0) begin
                way      = model_rr;                // Full set
                model_rr = (model_rr + 1) % ways;
            end
            exp_ar      = 1;
            exp_ar_addr = line;
            if (model_valid[set][way] && model_dirty[set][way]) begin
                exp_aw      = 1;
                exp_aw_addr = model_line[set][way];
                for (int i = 0; i < dcache_pkg::words_per_line; i++) begin
                    exp_line[64*i +: 64] = model_word(exp_aw_addr + 8*i);
                end
            end
            model_valid[set][way] = 1'b1;
            model_line[set][way]  = line;
            model_dirty[set][way] = 1'b0;
        end
        exp_rdata  = model_word(addr) & mask;
        check_read = !is_write;
        if (is_write) begin
            model_mem[addr]       = (model_word(addr) & ~mask) | (wdata & mask);
            model_dirty[set][way] = 1'b1;
        end
        ar_base = ar_count;
        aw_base = aw_count;
        w_base  = w_count;
        @(posedge clock);
        req <= '{read: !is_write, write: is_write, addr: addr, size: size, wdata: wdata};
        do @(negedge clock); while (!ack);
        check_req = 1'b1;
        @(posedge clock);
        check_req <= 1'b0;
        req.read  <= 1'b0;
        req.write <= 1'b0;
        do @(negedge clock); while (ack);
    endtask

    // Bus monitor
    always @(posedge clock) begin
        reset_q <= reset;
        if (ar.valid && arready) begin
            ar_count     <= ar_count + 1;
            last_ar_addr <= ar.addr;
        end
        if (aw.valid && awready) begin
            aw_count     <= aw_count + 1;
            last_aw_addr <= aw.addr;
        end
        if (w.valid && wready) begin
            w_count <= w_count + 1;
            w_beat  <= w_beat + 1'b1;  // Wraps after eight beats
        end
    end

    assert property (@(posedge clock) reset_q |->
                     !ack && !ar.valid && !aw.valid && !w.valid && !rready && !bready)
        else report_mismatch("an output is high during or just after reset");
    assert property (@(posedge clock) disable iff (reset) ar.valid |-> ar.addr[5:0] == 6'd0)
        else report_mismatch("read address is not line-aligned");
    assert property (@(posedge clock) disable iff (reset)
                     (w.valid && wready) |-> w.strb == 8'hff && w.last == (w_beat == 3'd7))
        else report_mismatch("write beat has wrong strobes or last flag");
    assert property (@(posedge clock) disable iff (reset)
                     (w.valid && wready) |-> w.data == exp_line[64*w_beat +: 64])
        else report_mismatch("write-back beat differs from the modelled line");
    assert property (@(posedge clock) check_req |-> ar_count - ar_base == exp_ar)
        else report_mismatch("wrong number of read bursts for the request");
    assert property (@(posedge clock) check_req && exp_ar == 1 |-> last_ar_addr == exp_ar_addr)
        else report_mismatch("fill read the wrong line");
    assert property (@(posedge clock) check_req |->
                     aw_count - aw_base == exp_aw && w_count - w_base == 8 * exp_aw)
        else report_mismatch("wrong number of write bursts or beats for the request");
    assert property (@(posedge clock) check_req && exp_aw == 1 |-> last_aw_addr == exp_aw_addr)
        else report_mismatch("write-back went to the wrong line");
    assert property (@(posedge clock) check_req && check_read |-> rdata == exp_rdata)
        else report_mismatch("read data differs from the model");

    initial begin
        repeat (8 + cycles_per_request * num_requests) @(posedge clock);
        report_failure("Watchdog expired before all requests completed");
    end

    initial begin
        reset      = 1'b1;
        req        = '0;
        check_req  = 1'b0;
        check_read = 1'b0;
        model_rr   = 0;
        for (int s = 0; s < sets; s++) begin
            for (int i = 0; i < ways; i++) begin
                model_valid[s][i] = 1'b0;
                model_dirty[s][i] = 1'b0;
            end
        end
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        // First pass misses at each size and fills every way, second pass hits
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < 4; i++) begin
                run_request(1'b0, dir_addr[i], size_codes[i], '0);
            end
        end
        run_request(1'b1, 32'h0000_1008, dcache_pkg::size_dword, 64'h0123_4567_89ab_cdef);
        run_request(1'b1, 32'h0000_3010, dcache_pkg::size_half, 64'h5a5a_5a5a_5a5a_c3c3);
        run_request(1'b0, 32'h0000_1008, dcache_pkg::size_dword, '0);  // Back from memory
        run_request(1'b0, 32'h0000_3010, dcache_pkg::size_dword, '0);  // Half merged into old word

        // Eight lines over two sets keep evictions coming
        for (int n = 0; n < random_requests; n++) begin
            rnd_write = $random(seed) & 1;
            rnd_addr  = 32'h0000_1000 + (($random(seed) & 7) << 6) + (($random(seed) & 7) << 3);
            rnd_size  = size_codes[($random(seed) & 32'h7fff_ffff) % 5];
            rnd_data  = {$random(seed), $random(seed)};
            run_request(rnd_write, rnd_addr, rnd_size, rnd_data);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

/* tb_axi_memory.sv */
`timescale 1ns/1ps

module tb_axi_memory #(
    parameter int seed_init = 0
) (
    input  logic                clock,
    input  logic                reset,
    input  dcache_pkg::axi_ar_t ar,
    output logic                arready,
    output dcache_pkg::axi_r_t  r,
    input  logic                rready,
    input  dcache_pkg::axi_aw_t aw,
    output logic                awready,
    input  dcache_pkg::axi_w_t  w,
    output logic                wready,
    output dcache_pkg::axi_b_t  b,
    input  logic                bready
);

    dcache_pkg::data_t mem [dcache_pkg::addr_t];  // Only words that were written
    integer            seed = seed_init;
    dcache_pkg::addr_t rd_addr;
    dcache_pkg::addr_t wr_addr;
    int                rd_left;  // Read beats still owed
    logic              wr_open;  // Write address taken, data beats may follow

    // Unwritten words hold the inverse of their own address
    function automatic dcache_pkg::data_t read_word(input dcache_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {32'h0, ~a};
    endfunction

    function automatic dcache_pkg::data_t merge_bytes(input dcache_pkg::data_t old,
                                                      input dcache_pkg::data_t data,
                                                      input dcache_pkg::strb_t strb);
        dcache_pkg::data_t result;
        result = old;
        for (int i = 0; i < 8; i++) begin
            if (strb[i]) result[8*i +: 8] = data[8*i +: 8];
        end
        return result;
    endfunction

    // Three cycles in four on average
    function automatic logic random_go();
        return ($random(seed) & 3) != 0;
    endfunction

    initial begin
        arready = 1'b0;
        r       = '0;
        awready = 1'b0;
        wready  = 1'b0;
        b       = '0;
        rd_left = 0;
        wr_open = 1'b0;
    end

    always @(posedge clock) begin
        if (reset) begin
            arready <= 1'b0;
            r       <= '0;
            awready <= 1'b0;
            wready  <= 1'b0;
            b       <= '0;
            rd_left <= 0;
            wr_open <= 1'b0;
        end else begin
            arready <= ar.valid && !arready && rd_left == 0 && random_go();
            if (ar.valid && arready) begin
                rd_addr <= ar.addr;
                rd_left <= dcache_pkg::words_per_line;
            end
            if (r.valid && rready) begin
                r.valid <= 1'b0;   // Gap of one cycle between beats
                rd_addr <= rd_addr + 8;
                rd_left <= rd_left - 1;
            end else if (rd_left > 0 && !r.valid && random_go()) begin
                r <= '{valid: 1'b1, last: rd_left == 1, data: read_word(rd_addr)};
            end

            awready <= aw.valid && !awready && !wr_open && random_go();
            if (aw.valid && awready) begin
                wr_addr <= aw.addr;
                wr_open <= 1'b1;
            end
            wready <= wr_open && !(w.valid && wready && w.last) && random_go();
            if (w.valid && wready) begin
                mem[wr_addr] = merge_bytes(read_word(wr_addr), w.data, w.strb);
                wr_addr <= wr_addr + 8;
                if (w.last) begin
                    wr_open <= 1'b0;
                    b       <= '{valid: 1'b1, resp: 2'b00};
                end
            end
            if (b.valid && bready) begin
                b.valid <= 1'b0;
            end
        end
    end

endmodule

/* dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
    parameter int num_sets = dcache_pkg::default_sets,
    parameter int num_ways = dcache_pkg::default_ways
) (
    input  logic                clock,
    input  logic                reset,
    input  dcache_pkg::cpu_req_t req,
    output logic                ack,
    output dcache_pkg::data_t   rdata,
    output dcache_pkg::axi_ar_t ar,
    input  logic                arready,
    input  dcache_pkg::axi_r_t  r,
    output logic                rready,
    output dcache_pkg::axi_aw_t aw,
    input  logic                awready,
    output dcache_pkg::axi_w_t  w,
    input  logic                wready,
    input  dcache_pkg::axi_b_t  b,
    output logic                bready
);

    logic hit;
    logic victim_dirty;
    logic lookup;
    logic alloc;
    logic mark_dirty;
    logic word_write;
    logic start_read;
    logic start_write;
    logic fill_done;
    logic drain_done;
    logic fill_accept;
    logic drain_advance;
    logic [$clog2(num_ways)-1:0] hit_way;
    dcache_pkg::addr_t victim_addr;
    dcache_pkg::addr_t line_addr;
    dcache_pkg::data_t drain_data;

    // Write-back goes to the victim line, a fill to the requested line
    assign line_addr = start_write ? victim_addr : req.addr;

    dcache_control u_control (
        .clock        (clock),
        .reset        (reset),
        .req          (req),
        .ack          (ack),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .lookup       (lookup),
        .alloc        (alloc),
        .mark_dirty   (mark_dirty),
        .word_write   (word_write),
        .start_read   (start_read),
        .start_write  (start_write),
        .fill_done    (fill_done),
        .drain_done   (drain_done)
    );

    tag_store #(
        .num_sets (num_sets),
        .num_ways (num_ways)
    ) u_tags (
        .clock        (clock),
        .reset        (reset),
        .addr         (req.addr),
        .lookup       (lookup),
        .alloc        (alloc),
        .mark_dirty   (mark_dirty),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr)
    );

    line_store #(
        .num_sets (num_sets),
        .num_ways (num_ways)
    ) u_lines (
        .clock         (clock),
        .addr          (req.addr),
        .line_way      (hit_way),
        .size          (req.size),
        .wdata         (req.wdata),
        .word_write    (word_write),
        .rdata         (rdata),
        .fill_beat     (r),
        .fill_accept   (fill_accept),
        .drain_data    (drain_data),
        .drain_advance (drain_advance)
    );

    axi_burst_master u_master (
        .clock         (clock),
        .reset         (reset),
        .start_read    (start_read),
        .start_write   (start_write),
        .line_addr     (line_addr),
        .ar            (ar),
        .arready       (arready),
        .r             (r),
        .rready        (rready),
        .fill_accept   (fill_accept),
        .aw            (aw),
        .awready       (awready),
        .w             (w),
        .wready        (wready),
        .drain_data    (drain_data),
        .drain_advance (drain_advance),
        .b             (b),
        .bready        (bready),
        .fill_done     (fill_done),
        .drain_done    (drain_done)
    );

endmodule

/* dcache_control.sv */
`timescale 1ns/1ps

module dcache_control (
    input  logic                 clock,
    input  logic                 reset,
    input  dcache_pkg::cpu_req_t req,
    output logic                 ack,
    input  logic                 hit,
    input  logic                 victim_dirty,
    output logic                 lookup,
    output logic                 alloc,
    output logic                 mark_dirty,
    output logic                 word_write,
    output logic                 start_read,
    output logic                 start_write,
    input  logic                 fill_done,
    input  logic                 drain_done
);

    dcache_pkg::ctrl_state_e state;
    dcache_pkg::ctrl_state_e next_state;
    logic is_write;     // Captured operation of the request in flight
    logic req_active;

    assign req_active = req.read || req.write;

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= dcache_pkg::st_idle;
            is_write <= 1'b0;
        end else begin
            state <= next_state;
            if (state == dcache_pkg::st_idle && req_active) begin
                is_write <= req.write;
            end
        end
    end

    always_comb begin
        next_state  = state;
        lookup      = 1'b0;
        alloc       = 1'b0;
        mark_dirty  = 1'b0;
        word_write  = 1'b0;
        start_read  = 1'b0;
        start_write = 1'b0;

        case (state)
            dcache_pkg::st_idle: begin
                if (req_active) begin
                    next_state = dcache_pkg::st_lookup;
                end
            end

            dcache_pkg::st_lookup: begin
                lookup = 1'b1;  // Tag store latches its victim choice here
                if (hit) begin
                    next_state = is_write ? dcache_pkg::st_merge : dcache_pkg::st_respond;
                end else begin
                    next_state = dcache_pkg::st_evict_check;
                end
            end

            dcache_pkg::st_evict_check: begin
                if (victim_dirty) begin
                    next_state = dcache_pkg::st_write_back;
                end else begin
                    start_read = 1'b1;  // Clean or empty victim, refill at once
                    next_state = dcache_pkg::st_fill;
                end
            end

            dcache_pkg::st_write_back: begin
                start_write = 1'b1;
                next_state  = dcache_pkg::st_wait_back;
            end

            dcache_pkg::st_wait_back: begin
                // Fill starts only once memory has answered the write
                if (drain_done) begin
                    start_read = 1'b1;
                    next_state = dcache_pkg::st_fill;
                end
            end

            dcache_pkg::st_fill: begin
                if (fill_done) begin
                    alloc      = 1'b1;  // All eight beats are in, install the tag
                    next_state = is_write ? dcache_pkg::st_merge : dcache_pkg::st_respond;
                end
            end

            dcache_pkg::st_merge: begin
                word_write = 1'b1;
                mark_dirty = 1'b1;
                next_state = dcache_pkg::st_respond;
            end

            dcache_pkg::st_respond: begin
                next_state = dcache_pkg::st_release;
            end

            dcache_pkg::st_release: begin
                if (!req_active) begin
                    next_state = dcache_pkg::st_idle;
                end
            end

            default: begin
                next_state = dcache_pkg::st_idle;
            end
        endcase
    end

    // Held from respond until the cycle after the request drops
    assign ack = (state == dcache_pkg::st_respond) || (state == dcache_pkg::st_release);

endmodule

/* axi_burst_master.sv */
`timescale 1ns/1ps

module axi_burst_master (
    input  logic                clock,
    input  logic                reset,
    input  logic                start_read,
    input  logic                start_write,
    input  dcache_pkg::addr_t   line_addr,
    output dcache_pkg::axi_ar_t ar,
    input  logic                arready,
    input  dcache_pkg::axi_r_t  r,
    output logic                rready,
    output logic                fill_accept,
    output dcache_pkg::axi_aw_t aw,
    input  logic                awready,
    output dcache_pkg::axi_w_t  w,
    input  logic                wready,
    input  dcache_pkg::data_t   drain_data,
    output logic                drain_advance,
    input  dcache_pkg::axi_b_t  b,
    output logic                bready,
    output logic                fill_done,
    output logic                drain_done
);

    dcache_pkg::addr_t     line_base;
    dcache_pkg::addr_t     ar_addr;
    dcache_pkg::addr_t     aw_addr;
    logic                  ar_valid;
    logic                  aw_valid;
    logic                  w_valid;
    logic                  w_last;
    logic                  r_fire;
    logic                  w_fire;
    logic                  b_fire;
    dcache_pkg::word_idx_t wr_cnt;  // Write beats sent so far

    assign line_base = {line_addr[$bits(dcache_pkg::addr_t)-1:dcache_pkg::offset_bits],
                        {dcache_pkg::offset_bits{1'b0}}};

    assign r_fire = r.valid && rready;
    assign w_fire = w_valid && wready;
    assign b_fire = b.valid && bready;
    assign w_last = (wr_cnt == dcache_pkg::word_idx_t'(dcache_pkg::words_per_line - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            ar_valid   <= 1'b0;
            aw_valid   <= 1'b0;
            w_valid    <= 1'b0;
            rready     <= 1'b0;
            bready     <= 1'b0;
            wr_cnt     <= '0;
            fill_done  <= 1'b0;
            drain_done <= 1'b0;
        end else begin
            fill_done  <= r_fire && r.last;
            drain_done <= b_fire;  // Response code is ignored

            if (start_read) begin
                ar_valid <= 1'b1;
                rready   <= 1'b1;
            end else begin
                if (ar_valid && arready) ar_valid <= 1'b0;
                if (r_fire && r.last) rready <= 1'b0;
            end

            // Address and data channels run side by side
            if (start_write) begin
                aw_valid <= 1'b1;
                w_valid  <= 1'b1;
                wr_cnt   <= '0;
            end else begin
                if (aw_valid && awready) aw_valid <= 1'b0;
                if (w_fire) begin
                    wr_cnt <= wr_cnt + 1'b1;
                    if (w_last) begin
                        w_valid <= 1'b0;
                        bready  <= 1'b1;
                    end
                end
                if (b_fire) bready <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start_read) ar_addr <= line_base;
        if (start_write) aw_addr <= line_base;
    end

    assign ar = '{valid: ar_valid, addr: ar_addr};
    assign aw = '{valid: aw_valid, addr: aw_addr};
    assign w  = '{valid: w_valid, data: drain_data, strb: '1, last: w_last};

    assign fill_accept   = r_fire;
    assign drain_advance = w_fire;  // Line store steps to the next word

endmodule

/* line_store.sv */
`timescale 1ns/1ps

module line_store #(
    parameter int num_sets = dcache_pkg::default_sets,
    parameter int num_ways = dcache_pkg::default_ways
) (
    input  logic                        clock,
    input  dcache_pkg::addr_t           addr,
    input  logic [$clog2(num_ways)-1:0] line_way,
    input  dcache_pkg::size_t           size,
    input  dcache_pkg::data_t           wdata,
    input  logic                        word_write,
    output dcache_pkg::data_t           rdata,
    input  dcache_pkg::axi_r_t          fill_beat,
    input  logic                        fill_accept,
    output dcache_pkg::data_t           drain_data,
    input  logic                        drain_advance
);

    localparam int set_bits  = $clog2(num_sets);
    localparam int word_bits = $bits(dcache_pkg::data_t);

    dcache_pkg::line_t lines [num_sets][num_ways];

    logic [set_bits-1:0]   set_idx;
    dcache_pkg::word_idx_t word_idx;
    dcache_pkg::word_idx_t fill_cnt  = '0;  // Both counters wrap back to 0 after 8 beats
    dcache_pkg::word_idx_t drain_cnt = '0;
    dcache_pkg::data_t     word;
    dcache_pkg::data_t     mask;

    assign set_idx  = addr[dcache_pkg::offset_bits +: set_bits];
    assign word_idx = addr[dcache_pkg::offset_bits-1:3];
    assign word     = lines[set_idx][line_way][word_idx*word_bits +: word_bits];

    // Low bytes covered by the size code
    always_comb begin
        case (size)
            dcache_pkg::size_byte:  mask = 64'h0000_0000_0000_00ff;
            dcache_pkg::size_half:  mask = 64'h0000_0000_0000_ffff;
            dcache_pkg::size_word:  mask = 64'h0000_0000_ffff_ffff;
            dcache_pkg::size_dword: mask = 64'hffff_ffff_ffff_ffff;
            default:                mask = '0;
        endcase
    end

    assign rdata = word & mask;  // Zero-extended sized load

    always_ff @(posedge clock) begin
        if (fill_accept) begin
            lines[set_idx][line_way][fill_cnt*word_bits +: word_bits] <= fill_beat.data;
            fill_cnt <= fill_cnt + 1'b1;
        end else if (word_write) begin
            lines[set_idx][line_way][word_idx*word_bits +: word_bits] <=
                (word & ~mask) | (wdata & mask);
        end
        if (drain_advance) begin
            drain_cnt <= drain_cnt + 1'b1;
        end
    end

    assign drain_data = lines[set_idx][line_way][drain_cnt*word_bits +: word_bits];

endmodule

/* tag_store.sv */
`timescale 1ns/1ps

module tag_store #(
    parameter int num_sets = dcache_pkg::default_sets,
    parameter int num_ways = dcache_pkg::default_ways
) (
    input  logic                        clock,
    input  logic                        reset,
    input  dcache_pkg::addr_t           addr,
    input  logic                        lookup,
    input  logic                        alloc,
    input  logic                        mark_dirty,
    output logic                        hit,
    output logic [$clog2(num_ways)-1:0] hit_way,
    output logic                        victim_dirty,
    output dcache_pkg::addr_t           victim_addr
);

    localparam int set_bits = $clog2(num_sets);
    localparam int way_bits = $clog2(num_ways);
    localparam int tag_bits = $bits(dcache_pkg::addr_t) - dcache_pkg::offset_bits - set_bits;

    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [way_bits-1:0] way_t;

    tag_t                tags  [num_sets][num_ways];
    logic [num_ways-1:0] valid [num_sets];
    logic [num_ways-1:0] dirty [num_sets];

    logic [set_bits-1:0] set_idx;
    tag_t                tag;
    way_t                match_way;
    way_t                free_way;
    logic                has_free;
    way_t                rr_ptr;   // Next way to replace in a full set
    way_t                victim;   // Way chosen at lookup, held until the next one

    assign set_idx = addr[dcache_pkg::offset_bits +: set_bits];
    assign tag     = addr[$bits(dcache_pkg::addr_t)-1 -: tag_bits];

    // Lowest index wins for both the match and the free way
    always_comb begin
        hit       = 1'b0;
        match_way = '0;
        has_free  = 1'b0;
        free_way  = '0;
        for (int i = num_ways - 1; i >= 0; i--) begin
            if (valid[set_idx][i] && tags[set_idx][i] == tag) begin
                hit       = 1'b1;
                match_way = way_t'(i);
            end
            if (!valid[set_idx][i]) begin
                has_free = 1'b1;
                free_way = way_t'(i);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
            rr_ptr <= '0;
            victim <= '0;
        end else begin
            if (lookup) begin
                victim <= has_free ? free_way : rr_ptr;
            end
            if (alloc) begin
                valid[set_idx][victim] <= 1'b1;
                dirty[set_idx][victim] <= 1'b0;
                if (!has_free) begin
                    rr_ptr <= (rr_ptr == way_t'(num_ways - 1)) ? '0 : rr_ptr + 1'b1;
                end
            end
            if (mark_dirty && hit) begin
                dirty[set_idx][match_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            tags[set_idx][victim] <= tag;
        end
    end

    assign hit_way      = hit ? match_way : victim;  // Also selects the line to fill or drain
    assign victim_dirty = valid[set_idx][victim] && dirty[set_idx][victim];
    assign victim_addr  = {tags[set_idx][victim], set_idx, {dcache_pkg::offset_bits{1'b0}}};

endmodule

/* dcache_pkg.sv */
package dcache_pkg;

    typedef logic [31:0]  addr_t;      // Byte address
    typedef logic [63:0]  data_t;      // One data word, also one AXI beat
    typedef logic [7:0]   strb_t;      // Byte enables of one beat
    typedef logic [511:0] line_t;      // Whole cache line
    typedef logic [2:0]   word_idx_t;  // Word within a line
    typedef logic [2:0]   size_t;      // Access size code

    localparam int words_per_line = 8;
    localparam int offset_bits    = 6;  // Line offset in the byte address

    localparam int default_sets = 2;
    localparam int default_ways = 2;

    // Size codes, any other code reads zero and writes nothing
    localparam size_t size_byte  = 3'd1;
    localparam size_t size_half  = 3'd2;
    localparam size_t size_word  = 3'd4;
    localparam size_t size_dword = 3'd7;

    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        size_t size;
        data_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } axi_ar_t;

    typedef struct packed {
        logic  valid;
        logic  last;
        data_t data;
    } axi_r_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } axi_aw_t;

    typedef struct packed {
        logic  valid;
        data_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } axi_b_t;

    // release is a keyword, so every state carries the st_ prefix
    typedef enum logic [3:0] {
        st_idle,
        st_lookup,
        st_evict_check,
        st_write_back,
        st_wait_back,
        st_fill,
        st_merge,
        st_respond,
        st_release
    } ctrl_state_e;

endpackage
